// File: compile.f
+incdir+.
ccip_wr_pkg.sv
burst_len_fifo.sv
wr_burst_sequencer.sv
wr_tx_register.sv
wr_response_tracker.sv
avmm_ccip_host_wr.sv
tb_avmm_ccip_host_wr.sv

// File: Bender.yml
package:
  name: avmm_ccip_host_wr

export_include_dirs:
  - .

sources:
  - files:
      - ccip_wr_pkg.sv
      - burst_len_fifo.sv
      - wr_burst_sequencer.sv
      - wr_tx_register.sv
      - wr_response_tracker.sv
      - avmm_ccip_host_wr.sv
  - target: simulation
    files:
      - tb_avmm_ccip_host_wr.sv

// File: tb_avmm_ccip_host_wr.sv
// testbench for the avalon to CCI-P host write bridge with a host response model
`timescale 1ns/1ps
`include "ccip_wr_config.svh"

module tb_avmm_ccip_host_wr;
	import ccip_wr_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int LINE_OFFSET = 6;

	logic clk;
	logic reset;
	logic avmm_write;
	avmm_addr_t avmm_address;
	burst_len_t avmm_burstcount;
	line_data_t avmm_writedata;
	logic avmm_waitrequest;
	logic [1:0] avmm_write_response;
	logic avmm_write_responsevalid;
	logic c1_tx_almost_full;
	c1_rsp_t c1_rx;
	c1_req_t c1_tx;

	// expected requests in issue order, and burst lengths still owed a response
	c1_req_t exp_q[$];
	int burst_q[$];
	// host responses waiting for their due cycle
	c1_rsp_t rsp_q[$];
	int rsp_due[$];

	int seed = 27062;
	int cycle_cnt = 0;
	int beats_issued = 0;
	int bursts_issued = 0;
	int pulse_cnt = 0;
	int lines_returned = 0;
	int lines_done = 0;
	int last_due = 0;
	int due;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int errs_before;
	mdata_t mdata_exp = '0;
	c1_req_t exp_req;
	c1_rsp_t rsp;
	avmm_addr_t rnd_addr;

	avmm_ccip_host_wr avmm_ccip_host_wr_inst
	(
		.clk(clk),
		.reset(reset),
		.avmm_write(avmm_write),
		.avmm_address(avmm_address),
		.avmm_burstcount(avmm_burstcount),
		.avmm_writedata(avmm_writedata),
		.avmm_waitrequest(avmm_waitrequest),
		.avmm_write_response(avmm_write_response),
		.avmm_write_responsevalid(avmm_write_responsevalid),
		.c1_tx_almost_full(c1_tx_almost_full),
		.c1_rx(c1_rx),
		.c1_tx(c1_tx)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ************************************************************************
	// reference model
	// ************************************************************************

	// line contents follow the whole line address so misrouted lines show up
	function automatic line_data_t line_pattern(input line_addr_t a);
		return {8{~a[21:0], a}};
	endfunction

	// the idx-th request that a burst of len beats at addr must produce
	function automatic c1_req_t expected_req(input avmm_addr_t addr, input int len, input int idx);
		c1_req_t r;
		line_addr_t line;
		logic fence;
		logic aligned;
		int beat;
		r = '0;
		line = addr[`CCIP_WR_FENCE_BIT-1:LINE_OFFSET];
		fence = addr[`CCIP_WR_FENCE_BIT];
		aligned = (len == 1) || (len == 2 && !line[0]) || (len == 4 && line[1:0] == 2'b00);
		r.valid = 1'b1;
		r.cl_len = CL_LEN_1;
		if (fence && idx == 0)
		begin
			// the fence leads and carries no address
			r.req_type = REQ_WRFENCE;
			return r;
		end
		beat = fence ? idx - 1 : idx;
		r.req_type = REQ_WRLINE_I;
		r.sop = !aligned || (beat == 0);
		if (aligned && len == 2)
			r.cl_len = CL_LEN_2;
		else if (aligned && len == 4)
			r.cl_len = CL_LEN_4;
		r.address = line + beat;
		r.data = line_pattern(r.address);
		return r;
	endfunction

	task automatic report_mismatch(input string sig, input logic [511:0] exp_v,
		input logic [511:0] got_v);
		$display("MISMATCH at %0t: %s expected %0h got %0h", $time, sig, exp_v, got_v);
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
	endtask

	// ************************************************************************
	// compare process and host model
	// ************************************************************************

	always @(negedge clk)
	begin
		cycle_cnt++;
		// a burst response must be backed by lines the host already returned
		if (!reset && avmm_write_responsevalid)
		begin
			checks++;
			pulse_cnt++;
			if (burst_q.size() == 0)
				report_error("write response with no outstanding burst");
			else
				lines_done += burst_q.pop_front();
			if (lines_done > lines_returned)
				report_error("write response came before the host returned its lines");
			if (avmm_write_response !== 2'b00)
				report_mismatch("avmm_write_response", 2'b00, avmm_write_response);
		end
		if (!reset && c1_tx.valid)
		begin
			checks++;
			if (exp_q.size() == 0)
				report_error("request on c1_tx that no burst asked for");
			else
			begin
				exp_req = exp_q.pop_front();
				if (c1_tx.req_type !== exp_req.req_type)
					report_mismatch("c1_tx.req_type", exp_req.req_type, c1_tx.req_type);
				if (c1_tx.sop !== exp_req.sop)
					report_mismatch("c1_tx.sop", exp_req.sop, c1_tx.sop);
				if (c1_tx.cl_len !== exp_req.cl_len)
					report_mismatch("c1_tx.cl_len", exp_req.cl_len, c1_tx.cl_len);
				if (c1_tx.address !== exp_req.address)
					report_mismatch("c1_tx.address", exp_req.address, c1_tx.address);
				if (c1_tx.mdata !== mdata_exp)
					report_mismatch("c1_tx.mdata", mdata_exp, c1_tx.mdata);
				if (exp_req.req_type == REQ_WRLINE_I && c1_tx.data !== exp_req.data)
					report_mismatch("c1_tx.data", exp_req.data, c1_tx.data);
				// the host answers each packet once, fences with a non-line response
				if (exp_req.req_type == REQ_WRFENCE || exp_req.sop)
				begin
					rsp.rsp_valid = 1'b1;
					rsp.resp_type = (exp_req.req_type == REQ_WRFENCE) ? RSP_OTHER : RSP_WRLINE;
					rsp.cl_num = (exp_req.req_type == REQ_WRFENCE) ? 2'd0 : exp_req.cl_len;
					due = cycle_cnt + 2 + ({$random(seed)} % 9);
					if (due <= last_due)
						due = last_due + 1;
					last_due = due;
					rsp_q.push_back(rsp);
					rsp_due.push_back(due);
				end
			end
			mdata_exp++;
		end
		c1_rx = '0;
		if (rsp_due.size() > 0 && rsp_due[0] <= cycle_cnt)
		begin
			c1_rx = rsp_q.pop_front();
			rsp_due.delete(0);
			if (c1_rx.resp_type == RSP_WRLINE)
				lines_returned += c1_rx.cl_num + 1;
		end
	end

	// ************************************************************************
	// stimulus
	// ************************************************************************

	task automatic send_burst(input avmm_addr_t addr, input int len);
		int n;
		int b;
		logic fence;
		logic accepted;
		line_addr_t line;
		fence = addr[`CCIP_WR_FENCE_BIT];
		line = addr[`CCIP_WR_FENCE_BIT-1:LINE_OFFSET];
		for (n = 0; n < len + fence; n++)
			exp_q.push_back(expected_req(addr, len, n));
		burst_q.push_back(len);
		bursts_issued++;
		beats_issued += len;
		for (b = 0; b < len; b++)
		begin
			accepted = 1'b0;
			while (!accepted)
			begin
				@(negedge clk);
				avmm_write = 1'b1;
				avmm_address = addr;
				avmm_burstcount = burst_len_t'(len);
				avmm_writedata = line_pattern(line + b);
				// waitrequest only moves at the rising edge, so mid-low is stable
				#(CLK_PERIOD / 4);
				accepted = !avmm_waitrequest;
			end
		end
		@(negedge clk);
		avmm_write = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0 || burst_q.size() != 0)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic end_test(input int num, input string name);
		wait_idle();
		tests_run++;
		$display("test %0d %s: %0d errors", num, name, errors - errs_before);
		errs_before = errors;
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		avmm_write = 1'b0;
		avmm_address = '0;
		avmm_burstcount = '0;
		avmm_writedata = '0;
		c1_tx_almost_full = 1'b0;
		c1_rx = '0;
		errs_before = 0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		checks++;
		if (!avmm_waitrequest || c1_tx.valid || avmm_write_responsevalid)
			report_error("bridge not idle with waitrequest high right after reset");
		send_burst(49'h0_0000_1234_5600, 4);
		end_test(1, "aligned burst of 4");
		send_burst(49'h0_0000_0004_0040, 4);
		send_burst(49'h0_0000_0008_00c0, 2);
		send_burst(49'h0_0000_000c_0000, 3);
		end_test(2, "chopped bursts");
		send_burst(49'h1_0000_0abc_de40, 1);
		end_test(3, "write fence");
		repeat (8)
		begin
			rnd_addr = {1'b0, 10'h0, 32'({$random(seed)}), 6'h0};
			send_burst(rnd_addr, 1 + ({$random(seed)} % 4));
		end
		end_test(4, "mixed bursts and responses");
		@(negedge clk);
		c1_tx_almost_full = 1'b1;
		@(negedge clk);
		#(CLK_PERIOD / 4);
		checks++;
		if (!avmm_waitrequest)
			report_error("waitrequest did not rise one cycle after almost full");
		fork
			send_burst(49'h0_0000_0010_0080, 2);
			begin
				repeat (8)
				begin
					@(negedge clk);
					checks++;
					if (c1_tx.valid)
						report_error("request sent while almost full was high");
				end
				c1_tx_almost_full = 1'b0;
			end
		join
		end_test(5, "almost full backpressure");
		checks++;
		if (pulse_cnt != bursts_issued)
			report_error("number of write responses differs from number of bursts");
		$display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// the limit grows with every beat handed to the bridge
	initial
	begin
		while (cycle_cnt <= 200 * beats_issued + 1000)
			@(negedge clk);
		$display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: avmm_ccip_host_wr.sv
// avalon write master to CCI-P channel 1 host write bridge top level
`timescale 1ns/1ps

module avmm_ccip_host_wr
(
	input logic clk,
	input logic reset,
	input logic avmm_write,
	input ccip_wr_pkg::avmm_addr_t avmm_address,
	input ccip_wr_pkg::burst_len_t avmm_burstcount,
	input ccip_wr_pkg::line_data_t avmm_writedata,
	output logic avmm_waitrequest,
	output logic [1:0] avmm_write_response,
	output logic avmm_write_responsevalid,
	input logic c1_tx_almost_full,
	input ccip_wr_pkg::c1_rsp_t c1_rx,
	output ccip_wr_pkg::c1_req_t c1_tx
);
	import ccip_wr_pkg::*;

	logic ready;
	logic fifo_full;
	logic burst_push;
	burst_len_t burst_len;
	c1_req_t tx_next;

	// beats and fences become request headers one cycle ahead of the port
	wr_burst_sequencer wr_burst_sequencer_inst
	(
		.clk(clk),
		.reset(reset),
		.avmm_write(avmm_write),
		.avmm_address(avmm_address),
		.avmm_burstcount(avmm_burstcount),
		.avmm_writedata(avmm_writedata),
		.avmm_waitrequest(avmm_waitrequest),
		.ready(ready),
		.fifo_full(fifo_full),
		.burst_push(burst_push),
		.burst_len(burst_len),
		.tx_next(tx_next)
	);

	wr_tx_register wr_tx_register_inst
	(
		.clk(clk),
		.reset(reset),
		.c1_tx_almost_full(c1_tx_almost_full),
		.tx_next(tx_next),
		.ready(ready),
		.c1_tx(c1_tx)
	);

	// responses come back in burst order, one per accepted burst
	wr_response_tracker wr_response_tracker_inst
	(
		.clk(clk),
		.reset(reset),
		.burst_push(burst_push),
		.burst_len(burst_len),
		.c1_rx(c1_rx),
		.fifo_full(fifo_full),
		.avmm_write_response(avmm_write_response),
		.avmm_write_responsevalid(avmm_write_responsevalid)
	);

endmodule

// File: wr_response_tracker.sv
// write response tracker folding host line responses into one avalon response per burst
`timescale 1ns/1ps
`include "ccip_wr_config.svh"

module wr_response_tracker
(
	input logic clk,
	input logic reset,
	input logic burst_push,
	input ccip_wr_pkg::burst_len_t burst_len,
	input ccip_wr_pkg::c1_rsp_t c1_rx,
	output logic fifo_full,
	output logic [1:0] avmm_write_response,
	output logic avmm_write_responsevalid
);
	import ccip_wr_pkg::*;

	localparam int CNT_W = `CCIP_WR_RSP_CNT_WIDTH;
	localparam int CNT_XW = CNT_W + 1;
	localparam logic [1:0] AVMM_RSP_OKAY = 2'b00;

	logic fifo_empty;
	logic pop;
	burst_len_t head_len;
	logic incr;
	logic [CNT_W-1:0] rsp_cnt;
	logic [CNT_W-1:0] rsp_lines;
	logic [CNT_XW-1:0] cnt_next;

	burst_len_fifo burst_len_fifo_inst
	(
		.clk(clk),
		.reset(reset),
		.push(burst_push),
		.din(burst_len),
		.pop(pop),
		.dout(head_len),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	// responses arrive packed, cl_num plus one lines at a time
	assign incr = c1_rx.rsp_valid && (c1_rx.resp_type == RSP_WRLINE);
	assign rsp_lines = incr ? CNT_W'(c1_rx.cl_num) + 1'b1 : '0;

	// the oldest burst completes once enough lines have come back for it
	assign pop = !fifo_empty && (rsp_cnt >= head_len);

	// computed one bit wider so a wrap shows up in the top bit
	assign cnt_next = {1'b0, rsp_cnt} + CNT_XW'(rsp_lines) - (pop ? CNT_XW'(head_len) : '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rsp_cnt <= '0;
			avmm_write_responsevalid <= 1'b0;
		end
		else
		begin
			rsp_cnt <= cnt_next[CNT_W-1:0];
			avmm_write_responsevalid <= pop;
		end
	end

	// the host never reports a failed write
	assign avmm_write_response = AVMM_RSP_OKAY;

	assert property (@(posedge clk) disable iff (reset) !cnt_next[CNT_W])
		else $error("response line counter out of range");

endmodule

// File: wr_tx_register.sv
// channel 1 output register with the registered ready level and request tagging
`timescale 1ns/1ps

module wr_tx_register
(
	input logic clk,
	input logic reset,
	input logic c1_tx_almost_full,
	input ccip_wr_pkg::c1_req_t tx_next,
	output logic ready,
	output ccip_wr_pkg::c1_req_t c1_tx
);
	import ccip_wr_pkg::*;

	mdata_t mdata_cnt;

	// almost full leaves slack in the host queue, so one cycle of delay is safe
	always_ff @(posedge clk)
	begin
		if (reset)
			ready <= 1'b0;
		else
			ready <= !c1_tx_almost_full;
	end

	// every valid request, fences included, takes the next tag
	always_ff @(posedge clk)
	begin
		if (reset)
			mdata_cnt <= '0;
		else if (tx_next.valid)
			mdata_cnt <= mdata_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			c1_tx.valid <= 1'b0;
		else
			c1_tx.valid <= tx_next.valid;
		// the header fields, the tag and the line follow the sequencer every cycle
		c1_tx.sop <= tx_next.sop;
		c1_tx.cl_len <= tx_next.cl_len;
		c1_tx.req_type <= tx_next.req_type;
		c1_tx.address <= tx_next.address;
		c1_tx.mdata <= mdata_cnt;
		c1_tx.data <= tx_next.data;
	end

endmodule

// File: wr_burst_sequencer.sv
// burst sequencer turning avalon write beats and fences into host request headers
`timescale 1ns/1ps
`include "ccip_wr_config.svh"

module wr_burst_sequencer
(
	input logic clk,
	input logic reset,
	input logic avmm_write,
	input ccip_wr_pkg::avmm_addr_t avmm_address,
	input ccip_wr_pkg::burst_len_t avmm_burstcount,
	input ccip_wr_pkg::line_data_t avmm_writedata,
	output logic avmm_waitrequest,
	input logic ready,
	input logic fifo_full,
	output logic burst_push,
	output ccip_wr_pkg::burst_len_t burst_len,
	output ccip_wr_pkg::c1_req_t tx_next
);
	import ccip_wr_pkg::*;

	// byte offset bits below the line address
	localparam int LINE_OFFSET = `CCIP_WR_FENCE_BIT - `CCIP_WR_LINE_ADDR_WIDTH;

	logic [1:0] beat_cnt;
	line_addr_t addr_cnt;
	logic chopped;
	cl_len_e burst_cl_len;
	logic fence_done;
	logic burst_start;
	logic beat_accept;
	logic load;
	logic advance;
	logic unaligned;
	logic fence_pending;
	burst_len_t burst_m1;
	cl_len_e start_cl_len;
	line_addr_t in_line_addr;

	assign burst_start = (beat_cnt == 2'd0);
	assign in_line_addr = avmm_address[`CCIP_WR_FENCE_BIT-1:LINE_OFFSET];
	assign burst_m1 = avmm_burstcount - 3'd1;

	// a burst of 4 must sit on a 4-line boundary and a burst of 2 on a 2-line one
	// anything else, and every burst of 3, goes out one line at a time
	assign unaligned = ((avmm_burstcount == 3'd4) &&
			(avmm_address[LINE_OFFSET+1:LINE_OFFSET] != 2'b00)) ||
		((avmm_burstcount == 3'd2) && avmm_address[LINE_OFFSET]) ||
		(avmm_burstcount == 3'd3);

	always_comb
	begin
		start_cl_len = CL_LEN_1;
		if (!unaligned)
		begin
			case (avmm_burstcount)
				3'd2: start_cl_len = CL_LEN_2;
				3'd4: start_cl_len = CL_LEN_4;
				default: start_cl_len = CL_LEN_1;
			endcase
		end
	end

	// the fence goes out at the first beat of a fenced write without waiting for ready
	assign fence_pending = burst_start && avmm_write &&
		avmm_address[`CCIP_WR_FENCE_BIT] && !fence_done;

	// a full burst FIFO only stalls the start of a new burst
	assign avmm_waitrequest = !ready || fence_pending || (burst_start && fifo_full);
	assign beat_accept = avmm_write && !avmm_waitrequest;
	assign load = burst_start && beat_accept;
	assign advance = !burst_start && beat_accept;

	assign burst_push = load;
	assign burst_len = avmm_burstcount;

	// ************************************************************************
	// beat and address counters
	// ************************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			beat_cnt <= 2'd0;
			addr_cnt <= '0;
			chopped <= 1'b0;
			burst_cl_len <= CL_LEN_1;
			fence_done <= 1'b0;
		end
		else
		begin
			if (load)
			begin
				// the counter holds the beats still to come after this one
				beat_cnt <= burst_m1[1:0];
				addr_cnt <= in_line_addr + 1'b1;
				chopped <= unaligned;
				burst_cl_len <= start_cl_len;
			end
			else if (advance)
			begin
				beat_cnt <= beat_cnt - 2'd1;
				addr_cnt <= addr_cnt + 1'b1;
				if (beat_cnt == 2'd1)
					chopped <= 1'b0;
			end
			// the flag lets the data line of a fenced write through once
			if (load)
				fence_done <= 1'b0;
			else if (fence_pending)
				fence_done <= 1'b1;
		end
	end

	// ************************************************************************
	// request header
	// ************************************************************************

	always_comb
	begin
		tx_next = '0;
		tx_next.valid = beat_accept || fence_pending;
		tx_next.data = avmm_writedata;
		if (fence_pending)
		begin
			tx_next.sop = 1'b0;
			tx_next.cl_len = CL_LEN_1;
			tx_next.req_type = REQ_WRFENCE;
			tx_next.address = '0;
		end
		else
		begin
			// chopped bursts mark every line as its own packet
			tx_next.sop = burst_start || chopped;
			tx_next.cl_len = burst_start ? start_cl_len : burst_cl_len;
			tx_next.req_type = REQ_WRLINE_I;
			tx_next.address = burst_start ? in_line_addr : addr_cnt;
		end
	end

	// the beat counter only covers bursts of 1 to 4 lines
	assert property (@(posedge clk) disable iff (reset)
		burst_push |-> (burst_len != '0 && burst_len <= 3'd4))
		else $error("burst started with a burst count outside 1 to 4");

endmodule

// File: burst_len_fifo.sv
// show-ahead FIFO holding the lengths of outstanding avalon write bursts
`timescale 1ns/1ps
`include "ccip_wr_config.svh"

module burst_len_fifo
(
	input logic clk,
	input logic reset,
	input logic push,
	input ccip_wr_pkg::burst_len_t din,
	input logic pop,
	output ccip_wr_pkg::burst_len_t dout,
	output logic empty,
	output logic full
);
	import ccip_wr_pkg::*;

	localparam int DEPTH = `CCIP_WR_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	burst_len_t mem [DEPTH];

	// pointers carry one extra wrap bit to tell full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// the head entry is visible without a read cycle
	assign dout = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= din;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("burst FIFO overflow");

	assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else $error("burst FIFO underflow");

endmodule

// File: ccip_wr_pkg.sv
// types for the avalon to CCI-P host write bridge requests and responses
`include "ccip_wr_config.svh"

package ccip_wr_pkg;

	typedef logic [`CCIP_WR_DATA_WIDTH-1:0] line_data_t;
	typedef logic [`CCIP_WR_AVMM_ADDR_WIDTH-1:0] avmm_addr_t;
	typedef logic [`CCIP_WR_LINE_ADDR_WIDTH-1:0] line_addr_t;
	typedef logic [`CCIP_WR_BURST_WIDTH-1:0] burst_len_t;
	typedef logic [`CCIP_WR_MDATA_WIDTH-1:0] mdata_t;

	// request length as the host expects it, lines minus one
	typedef enum logic [1:0]
	{
		CL_LEN_1 = 2'b00,
		CL_LEN_2 = 2'b01,
		CL_LEN_4 = 2'b11
	} cl_len_e;

	typedef enum logic [3:0]
	{
		REQ_WRLINE_I = 4'h0,
		REQ_WRFENCE = 4'h4
	} req_type_e;

	// only write line responses count toward burst completion
	typedef enum logic [3:0]
	{
		RSP_WRLINE = 4'h1,
		RSP_OTHER = 4'h4
	} resp_type_e;

	// one TX channel 1 request, header fields first and the line last
	typedef struct packed
	{
		logic valid;
		logic sop;
		cl_len_e cl_len;
		req_type_e req_type;
		line_addr_t address;
		mdata_t mdata;
		line_data_t data;
	} c1_req_t;

	// a packed write response covers cl_num plus one lines
	typedef struct packed
	{
		logic rsp_valid;
		resp_type_e resp_type;
		logic [1:0] cl_num;
	} c1_rsp_t;

endpackage

// File: ccip_wr_config.svh
// host write bridge widths, depths and field positions shared by all blocks
`ifndef CCIP_WR_CONFIG_SVH
`define CCIP_WR_CONFIG_SVH

// one host cache line is carried per avalon beat
`define CCIP_WR_DATA_WIDTH 512

// avalon byte address, the top bit selects the write fence
`define CCIP_WR_AVMM_ADDR_WIDTH 49
`define CCIP_WR_FENCE_BIT 48

// host line address covers the 48-bit byte space in 64-byte lines
`define CCIP_WR_LINE_ADDR_WIDTH 42

// avalon bursts are 1 to 4 beats long
`define CCIP_WR_BURST_WIDTH 3

`define CCIP_WR_MDATA_WIDTH 16

// up to 64 bursts of 4 lines in flight, so the line counter needs 9 bits
`define CCIP_WR_FIFO_DEPTH 64
`define CCIP_WR_RSP_CNT_WIDTH 9

`endif
